// ==== design/sirius_pkg.sv ====
package sirius_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    localparam logic [xlen-1:0] reset_pc = 32'hbfc00000;

    // Major opcodes
    localparam logic [5:0] opcode_special = 6'h00;
    localparam logic [5:0] opcode_addiu   = 6'h09;
    localparam logic [5:0] opcode_andi    = 6'h0c;
    localparam logic [5:0] opcode_ori     = 6'h0d;
    localparam logic [5:0] opcode_xori    = 6'h0e;
    localparam logic [5:0] opcode_lui     = 6'h0f;

    // SPECIAL funct field
    localparam logic [5:0] funct_sll  = 6'h00;
    localparam logic [5:0] funct_addu = 6'h21;
    localparam logic [5:0] funct_subu = 6'h23;
    localparam logic [5:0] funct_and  = 6'h24;
    localparam logic [5:0] funct_or   = 6'h25;
    localparam logic [5:0] funct_xor  = 6'h26;
    localparam logic [5:0] funct_slt  = 6'h2a;

    typedef enum logic [3:0] {
        alu_nop,
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sll,
        alu_lui
    } alu_op_e;

    // One fetched word tagged with its address
    typedef struct packed {
        logic [xlen-1:0] instr;
        logic [xlen-1:0] pc;
    } fetch_entry_t;

    // Writeback record of one lane
    typedef struct packed {
        logic                  wen;
        logic [reg_addr_w-1:0] dest;
        logic [xlen-1:0]       data;
        logic [xlen-1:0]       pc;
    } wb_t;

endpackage

// ==== design/fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         full,
    input  logic                         inst_ok_1,
    input  logic                         inst_ok_2,
    input  logic [sirius_pkg::xlen-1:0]  inst_data_1,
    input  logic [sirius_pkg::xlen-1:0]  inst_data_2,
    output logic                         inst_en,
    output logic [sirius_pkg::xlen-1:0]  inst_addr,
    output logic [1:0]                   push_en,
    output sirius_pkg::fetch_entry_t     push_entry_0,
    output sirius_pkg::fetch_entry_t     push_entry_1
);

    logic take_1;
    logic take_2;

    assign inst_en = ~full;

    // Second word only counts together with the first
    assign take_1  = inst_en & inst_ok_1;
    assign take_2  = inst_en & inst_ok_1 & inst_ok_2;
    assign push_en = {take_2, take_1};

    assign push_entry_0 = '{instr: inst_data_1, pc: inst_addr};
    assign push_entry_1 = '{instr: inst_data_2, pc: inst_addr + 32'd4};

    always_ff @(posedge clk) begin
        if (rst) begin
            inst_addr <= sirius_pkg::reset_pc;
        end else if (take_2) begin
            inst_addr <= inst_addr + 32'd8;
        end else if (take_1) begin
            inst_addr <= inst_addr + 32'd4;
        end
    end

    a_ok_order : assert property (@(posedge clk) disable iff (rst)
        inst_en && inst_ok_2 |-> inst_ok_1);

endmodule

// ==== design/instruction_fifo.sv ====
`timescale 1ns/1ps

module instruction_fifo #(
    parameter int fifo_depth = 8
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [1:0]               push_en,
    input  sirius_pkg::fetch_entry_t push_entry_0,
    input  sirius_pkg::fetch_entry_t push_entry_1,
    input  logic [1:0]               pop_count,
    output sirius_pkg::fetch_entry_t head_0,
    output sirius_pkg::fetch_entry_t head_1,
    output logic                     head_0_valid,
    output logic                     head_1_valid,
    output logic                     full
);

    localparam int ptr_w = $clog2(fifo_depth);
    localparam int cnt_w = ptr_w + 1;

    sirius_pkg::fetch_entry_t mem [fifo_depth];

    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w-1:0] rd_ptr_nx;
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] wr_ptr_nx;
    logic [cnt_w-1:0] count;
    logic [1:0]       push_n;

    if ((fifo_depth < 4) || ((fifo_depth & (fifo_depth - 1)) != 0)) begin : g_depth_check
        $error("instruction_fifo: fifo_depth must be a power of two and at least 4");
    end

    assign push_n    = {1'b0, push_en[0]} + {1'b0, push_en[1]};
    assign rd_ptr_nx = rd_ptr + 1'b1;
    assign wr_ptr_nx = wr_ptr + 1'b1;

    // Oldest two entries
    assign head_0       = mem[rd_ptr];
    assign head_1       = mem[rd_ptr_nx];
    assign head_0_valid = (count >= cnt_w'(1));
    assign head_1_valid = (count >= cnt_w'(2));

    // Fewer than two free slots
    assign full = (count > cnt_w'(fifo_depth - 2));

    always_ff @(posedge clk) begin
        if (push_en[0]) begin
            mem[wr_ptr] <= push_entry_0;
        end
        if (push_en[1]) begin
            mem[wr_ptr_nx] <= push_entry_1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            rd_ptr <= rd_ptr + ptr_w'(pop_count);
            wr_ptr <= wr_ptr + ptr_w'(push_n);
            count  <= count + cnt_w'(push_n) - cnt_w'(pop_count);
        end
    end

    a_no_underflow : assert property (@(posedge clk) disable iff (rst)
        cnt_w'(pop_count) <= count);

    a_no_overflow : assert property (@(posedge clk) disable iff (rst)
        full |-> push_en == 2'b00);

endmodule

// ==== design/register_file.sv ====
`timescale 1ns/1ps

module register_file (
    input  logic                                clk,
    input  logic                                rst,
    input  logic [sirius_pkg::reg_addr_w-1:0]   raddr_0a,
    input  logic [sirius_pkg::reg_addr_w-1:0]   raddr_0b,
    input  logic [sirius_pkg::reg_addr_w-1:0]   raddr_1a,
    input  logic [sirius_pkg::reg_addr_w-1:0]   raddr_1b,
    input  sirius_pkg::wb_t                     wb_0,
    input  sirius_pkg::wb_t                     wb_1,
    output logic [sirius_pkg::xlen-1:0]         rdata_0a,
    output logic [sirius_pkg::xlen-1:0]         rdata_0b,
    output logic [sirius_pkg::xlen-1:0]         rdata_1a,
    output logic [sirius_pkg::xlen-1:0]         rdata_1b
);

    // r0 has no storage
    logic [sirius_pkg::xlen-1:0] regs [1:31];

    assign rdata_0a = (raddr_0a == '0) ? '0 : regs[raddr_0a];
    assign rdata_0b = (raddr_0b == '0) ? '0 : regs[raddr_0b];
    assign rdata_1a = (raddr_1a == '0) ? '0 : regs[raddr_1a];
    assign rdata_1b = (raddr_1b == '0) ? '0 : regs[raddr_1b];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wb_0.wen && wb_0.dest != '0) begin
                regs[wb_0.dest] <= wb_0.data;
            end
            // Younger lane lands last
            if (wb_1.wen && wb_1.dest != '0) begin
                regs[wb_1.dest] <= wb_1.data;
            end
        end
    end

endmodule

// ==== design/alu_lane.sv ====
`timescale 1ns/1ps

module alu_lane (
    input  sirius_pkg::alu_op_e          op,
    input  logic [sirius_pkg::xlen-1:0]  src_a,
    input  logic [sirius_pkg::xlen-1:0]  src_b,
    output logic [sirius_pkg::xlen-1:0]  result
);

    always_comb begin
        case (op)
            sirius_pkg::alu_add: begin
                result = src_a + src_b;
            end
            sirius_pkg::alu_sub: begin
                result = src_a - src_b;
            end
            sirius_pkg::alu_and: begin
                result = src_a & src_b;
            end
            sirius_pkg::alu_or: begin
                result = src_a | src_b;
            end
            sirius_pkg::alu_xor: begin
                result = src_a ^ src_b;
            end
            sirius_pkg::alu_slt: begin
                // Signed compare
                result = ($signed(src_a) < $signed(src_b)) ? 32'd1 : 32'd0;
            end
            sirius_pkg::alu_sll: begin
                result = src_b << src_a[4:0];
            end
            sirius_pkg::alu_lui: begin
                result = {src_b[15:0], 16'd0};
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

// ==== design/dual_issue_pipeline.sv ====
`timescale 1ns/1ps

module dual_issue_pipeline (
    input  logic                     clk,
    input  logic                     rst,
    input  sirius_pkg::fetch_entry_t head_0,
    input  sirius_pkg::fetch_entry_t head_1,
    input  logic                     head_0_valid,
    input  logic                     head_1_valid,
    output logic [1:0]               pop_count,
    output sirius_pkg::wb_t          wb_0,
    output sirius_pkg::wb_t          wb_1
);

    typedef struct packed {
        sirius_pkg::alu_op_e op;
        logic [4:0]          ra;
        logic [4:0]          rb;
        logic                use_ra;
        logic                use_rb;
        logic [31:0]         const_a;
        logic [31:0]         const_b;
        logic [4:0]          dest;
        logic                wen;
    } dec_t;

    typedef struct packed {
        sirius_pkg::alu_op_e op;
        logic [31:0]         src_a;
        logic [31:0]         src_b;
        logic [4:0]          dest;
        logic                wen;
        logic [31:0]         pc;
    } ex_t;

    dec_t        dec_0, dec_1;
    ex_t         ex_0, ex_1;
    logic        pair;
    logic [31:0] rf_0a, rf_0b, rf_1a, rf_1b;
    logic [31:0] opa_0, opb_0, opa_1, opb_1;
    logic [31:0] alu_res_0, alu_res_1;

    function automatic dec_t decode(input logic [31:0] instr);
        dec_t       d;
        logic [5:0] opcode;
        logic [5:0] funct;
        logic [15:0] imm;
        opcode    = instr[31:26];
        funct     = instr[5:0];
        imm       = instr[15:0];
        d.op      = sirius_pkg::alu_nop;
        d.ra      = instr[25:21];
        d.rb      = instr[20:16];
        d.use_ra  = 1'b1;
        d.use_rb  = 1'b0;
        d.const_a = '0;
        d.const_b = {16'd0, imm};
        d.dest    = instr[20:16];
        case (opcode)
            sirius_pkg::opcode_special: begin
                d.dest   = instr[15:11];
                d.use_rb = 1'b1;
                case (funct)
                    sirius_pkg::funct_addu: d.op = sirius_pkg::alu_add;
                    sirius_pkg::funct_subu: d.op = sirius_pkg::alu_sub;
                    sirius_pkg::funct_and:  d.op = sirius_pkg::alu_and;
                    sirius_pkg::funct_or:   d.op = sirius_pkg::alu_or;
                    sirius_pkg::funct_xor:  d.op = sirius_pkg::alu_xor;
                    sirius_pkg::funct_slt:  d.op = sirius_pkg::alu_slt;
                    sirius_pkg::funct_sll: begin
                        // Shift amount stands in for rs
                        d.op      = sirius_pkg::alu_sll;
                        d.use_ra  = 1'b0;
                        d.const_a = {27'd0, instr[10:6]};
                    end
                    default: d.op = sirius_pkg::alu_nop;
                endcase
            end
            sirius_pkg::opcode_addiu: begin
                d.op      = sirius_pkg::alu_add;
                d.const_b = {{16{imm[15]}}, imm};
            end
            sirius_pkg::opcode_andi: d.op = sirius_pkg::alu_and;
            sirius_pkg::opcode_ori:  d.op = sirius_pkg::alu_or;
            sirius_pkg::opcode_xori: d.op = sirius_pkg::alu_xor;
            sirius_pkg::opcode_lui: begin
                d.op     = sirius_pkg::alu_lui;
                d.use_ra = 1'b0;
            end
            default: d.op = sirius_pkg::alu_nop;
        endcase
        if (d.op == sirius_pkg::alu_nop) begin
            d.use_ra = 1'b0;
            d.use_rb = 1'b0;
        end
        d.wen = (d.op != sirius_pkg::alu_nop) && (d.dest != 5'd0);
        return d;
    endfunction

    // Youngest producer wins
    function automatic logic [31:0] operand(input logic use_r, input logic [4:0] addr,
                                            input logic [31:0] rf_val,
                                            input logic [31:0] konst);
        if (!use_r) begin
            return konst;
        end else if (ex_1.wen && ex_1.dest == addr) begin
            return alu_res_1;
        end else if (ex_0.wen && ex_0.dest == addr) begin
            return alu_res_0;
        end else if (wb_1.wen && wb_1.dest == addr) begin
            return wb_1.data;
        end else if (wb_0.wen && wb_0.dest == addr) begin
            return wb_0.data;
        end
        return rf_val;
    endfunction

    always_comb begin
        dec_0 = decode(head_0.instr);
        dec_1 = decode(head_1.instr);
    end

    // Slave lane only takes an independent instruction
    assign pair = head_0_valid && head_1_valid &&
                  !(dec_0.wen && ((dec_1.use_ra && dec_1.ra == dec_0.dest) ||
                                  (dec_1.use_rb && dec_1.rb == dec_0.dest)));

    assign pop_count = !head_0_valid ? 2'd0 : (pair ? 2'd2 : 2'd1);

    always_comb begin
        opa_0 = operand(dec_0.use_ra, dec_0.ra, rf_0a, dec_0.const_a);
        opb_0 = operand(dec_0.use_rb, dec_0.rb, rf_0b, dec_0.const_b);
        opa_1 = operand(dec_1.use_ra, dec_1.ra, rf_1a, dec_1.const_a);
        opb_1 = operand(dec_1.use_rb, dec_1.rb, rf_1b, dec_1.const_b);
    end

    register_file reg_file (
        .clk      (clk),
        .rst      (rst),
        .raddr_0a (dec_0.ra),
        .raddr_0b (dec_0.rb),
        .raddr_1a (dec_1.ra),
        .raddr_1b (dec_1.rb),
        .wb_0     (wb_0),
        .wb_1     (wb_1),
        .rdata_0a (rf_0a),
        .rdata_0b (rf_0b),
        .rdata_1a (rf_1a),
        .rdata_1b (rf_1b)
    );

    // Issue to execute
    always_ff @(posedge clk) begin
        if (rst) begin
            ex_0.wen <= 1'b0;
            ex_1.wen <= 1'b0;
        end else begin
            ex_0 <= '{op: dec_0.op, src_a: opa_0, src_b: opb_0, dest: dec_0.dest,
                      wen: head_0_valid && dec_0.wen, pc: head_0.pc};
            ex_1 <= '{op: dec_1.op, src_a: opa_1, src_b: opb_1, dest: dec_1.dest,
                      wen: pair && dec_1.wen, pc: head_1.pc};
        end
    end

    alu_lane lane0_alu (
        .op     (ex_0.op),
        .src_a  (ex_0.src_a),
        .src_b  (ex_0.src_b),
        .result (alu_res_0)
    );

    alu_lane lane1_alu (
        .op     (ex_1.op),
        .src_a  (ex_1.src_a),
        .src_b  (ex_1.src_b),
        .result (alu_res_1)
    );

    // Execute to writeback
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_0.wen <= 1'b0;
            wb_1.wen <= 1'b0;
        end else begin
            wb_0 <= '{wen: ex_0.wen, dest: ex_0.dest, data: alu_res_0, pc: ex_0.pc};
            wb_1 <= '{wen: ex_1.wen, dest: ex_1.dest, data: alu_res_1, pc: ex_1.pc};
        end
    end

endmodule

// ==== design/sirius_core.sv ====
`timescale 1ns/1ps

module sirius_core #(
    parameter int fifo_depth = 8
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         inst_ok_1,
    input  logic                         inst_ok_2,
    input  logic [sirius_pkg::xlen-1:0]  inst_data_1,
    input  logic [sirius_pkg::xlen-1:0]  inst_data_2,
    output logic                         inst_en,
    output logic [sirius_pkg::xlen-1:0]  inst_addr,
    output sirius_pkg::wb_t              wb_0,
    output sirius_pkg::wb_t              wb_1
);

    logic                     fifo_full;
    logic [1:0]               push_en;
    sirius_pkg::fetch_entry_t push_entry_0;
    sirius_pkg::fetch_entry_t push_entry_1;
    sirius_pkg::fetch_entry_t head_0;
    sirius_pkg::fetch_entry_t head_1;
    logic                     head_0_valid;
    logic                     head_1_valid;
    logic [1:0]               pop_count;

    fetch_unit fetch_0 (
        .clk          (clk),
        .rst          (rst),
        .full         (fifo_full),
        .inst_ok_1    (inst_ok_1),
        .inst_ok_2    (inst_ok_2),
        .inst_data_1  (inst_data_1),
        .inst_data_2  (inst_data_2),
        .inst_en      (inst_en),
        .inst_addr    (inst_addr),
        .push_en      (push_en),
        .push_entry_0 (push_entry_0),
        .push_entry_1 (push_entry_1)
    );

    instruction_fifo #(
        .fifo_depth (fifo_depth)
    ) instruction_fifo_0 (
        .clk          (clk),
        .rst          (rst),
        .push_en      (push_en),
        .push_entry_0 (push_entry_0),
        .push_entry_1 (push_entry_1),
        .pop_count    (pop_count),
        .head_0       (head_0),
        .head_1       (head_1),
        .head_0_valid (head_0_valid),
        .head_1_valid (head_1_valid),
        .full         (fifo_full)
    );

    dual_issue_pipeline pipeline_0 (
        .clk          (clk),
        .rst          (rst),
        .head_0       (head_0),
        .head_1       (head_1),
        .head_0_valid (head_0_valid),
        .head_1_valid (head_1_valid),
        .pop_count    (pop_count),
        .wb_0         (wb_0),
        .wb_1         (wb_1)
    );

endmodule

// ==== verification/sirius_tests.svh ====
function automatic logic [31:0] enc_r(input logic [5:0] funct, input logic [4:0] rs,
                                      input logic [4:0] rt, input logic [4:0] rd,
                                      input logic [4:0] sh);
    return {sirius_pkg::opcode_special, rs, rt, rd, sh, funct};
endfunction

function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rs,
                                      input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
endfunction

// Only r0 to r7 to make hazards frequent
function automatic logic [31:0] random_instr();
    logic [31:0] r;
    logic [31:0] k;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  rd;
    r  = next_rand();
    k  = next_rand();
    rs = {2'b00, r[2:0]};
    rt = {2'b00, r[5:3]};
    rd = {2'b00, r[8:6]};
    case (k % 12)
        0:  return enc_r(sirius_pkg::funct_addu, rs, rt, rd, 5'd0);
        1:  return enc_r(sirius_pkg::funct_subu, rs, rt, rd, 5'd0);
        2:  return enc_r(sirius_pkg::funct_and, rs, rt, rd, 5'd0);
        3:  return enc_r(sirius_pkg::funct_or, rs, rt, rd, 5'd0);
        4:  return enc_r(sirius_pkg::funct_xor, rs, rt, rd, 5'd0);
        5:  return enc_r(sirius_pkg::funct_slt, rs, rt, rd, 5'd0);
        6:  return enc_r(sirius_pkg::funct_sll, 5'd0, rt, rd, r[13:9]);
        7:  return enc_i(sirius_pkg::opcode_addiu, rs, rt, r[31:16]);
        8:  return enc_i(sirius_pkg::opcode_andi, rs, rt, r[31:16]);
        9:  return enc_i(sirius_pkg::opcode_ori, rs, rt, r[31:16]);
        10: return enc_i(sirius_pkg::opcode_xori, rs, rt, r[31:16]);
        default: return enc_i(sirius_pkg::opcode_lui, 5'd0, rt, r[31:16]);
    endcase
endfunction

task automatic test_reset_state();
    start_test("reset_state");
    @(negedge clk);
    check("inst_en", 32'd1, 32'(inst_en));
    check("inst_addr", sirius_pkg::reset_pc, inst_addr);
    check("wb_0 wen", 32'd0, 32'(wb_0.wen));
    check("wb_1 wen", 32'd0, 32'(wb_1.wen));
    repeat (10) @(negedge clk);
    end_test();
endtask

task automatic test_single_fetch();
    start_test("single_fetch");
    for (int i = 1; i < 9; i++)
        emit(enc_i(sirius_pkg::opcode_addiu, 5'd0, 5'(i), 16'(i * 37)));
    emit(enc_i(sirius_pkg::opcode_lui, 5'd0, 5'd9, 16'hbeef));
    emit(enc_i(sirius_pkg::opcode_ori, 5'd0, 5'd10, 16'h8001));
    emit(enc_i(sirius_pkg::opcode_addiu, 5'd0, 5'd11, 16'hfff0));
    start_fetch(0);
    finish_program();
    end_test();
endtask

task automatic test_dual_pairs();
    start_test("dual_pairs");
    emit(enc_i(sirius_pkg::opcode_addiu, 5'd0, 5'd1, 16'h0011));
    emit(enc_r(sirius_pkg::funct_addu, 5'd1, 5'd1, 5'd2, 5'd0));
    emit(enc_i(sirius_pkg::opcode_ori, 5'd0, 5'd3, 16'hf0f0));
    emit(enc_r(sirius_pkg::funct_subu, 5'd2, 5'd3, 5'd4, 5'd0));
    emit(enc_r(sirius_pkg::funct_sll, 5'd0, 5'd4, 5'd5, 5'd4));
    emit(enc_r(sirius_pkg::funct_xor, 5'd5, 5'd1, 5'd6, 5'd0));
    emit(enc_i(sirius_pkg::opcode_lui, 5'd0, 5'd7, 16'h8000));
    emit(enc_r(sirius_pkg::funct_slt, 5'd7, 5'd4, 5'd8, 5'd0));
    emit(enc_i(sirius_pkg::opcode_andi, 5'd6, 5'd9, 16'h00ff));
    emit(enc_i(sirius_pkg::opcode_addiu, 5'd9, 5'd10, 16'hfffd));
    emit(enc_i(sirius_pkg::opcode_xori, 5'd10, 5'd11, 16'h5555));
    emit(enc_r(sirius_pkg::funct_or, 5'd11, 5'd2, 5'd12, 5'd0));
    // Younger of two writes to one register must stick
    emit(enc_i(sirius_pkg::opcode_addiu, 5'd0, 5'd13, 16'h0001));
    emit(enc_i(sirius_pkg::opcode_addiu, 5'd0, 5'd13, 16'h0002));
    emit(enc_r(sirius_pkg::funct_addu, 5'd13, 5'd0, 5'd14, 5'd0));
    start_fetch(1);
    finish_program();
    end_test();
endtask

task automatic test_backpressure();
    int cycles;
    start_test("backpressure");
    for (int i = 0; i < 48; i++) begin
        if (i % 3 == 2) begin
            emit(enc_r(sirius_pkg::funct_addu, 5'd1, 5'd1, 5'd1, 5'd0));
        end else begin
            emit(enc_i(sirius_pkg::opcode_addiu, 5'd1, 5'd1, 16'(i + 1)));
        end
    end
    start_fetch(1);
    cycles = 0;
    do begin
        @(negedge clk);
        cycles++;
    end while (inst_en && cycles < 40);
    if (inst_en) begin
        errors++;
        $display("%s: inst_en never dropped while the FIFO was filling", test_name);
    end
    finish_program();
    end_test();
endtask

task automatic test_random_mix();
    start_test("random_mix");
    for (int i = 0; i < 120; i++)
        emit(random_instr());
    start_fetch(2);
    finish_program();
    end_test();
endtask

task automatic test_nop_handling();
    start_test("nop_handling");
    emit(enc_i(sirius_pkg::opcode_addiu, 5'd0, 5'd1, 16'h0007));
    emit(enc_i(sirius_pkg::opcode_addiu, 5'd1, 5'd0, 16'h0005));
    emit(32'hffffffff);
    // Unknown funct and a load opcode outside the subset
    emit(enc_r(6'h1a, 5'd1, 5'd1, 5'd3, 5'd0));
    emit(enc_i(6'h23, 5'd0, 5'd2, 16'h0004));
    emit(enc_r(sirius_pkg::funct_addu, 5'd1, 5'd1, 5'd2, 5'd0));
    emit(enc_r(sirius_pkg::funct_or, 5'd0, 5'd2, 5'd0, 5'd0));
    emit(enc_r(sirius_pkg::funct_or, 5'd0, 5'd2, 5'd4, 5'd0));
    emit(enc_r(sirius_pkg::funct_addu, 5'd3, 5'd4, 5'd5, 5'd0));
    start_fetch(1);
    finish_program();
    end_test();
endtask

// ==== verification/sirius_tb.sv ====
`timescale 1ns/1ps

module sirius_tb;

    logic            clk;
    logic            rst;
    logic            inst_ok_1;
    logic            inst_ok_2;
    logic [31:0]     inst_data_1;
    logic [31:0]     inst_data_2;
    logic            inst_en;
    logic [31:0]     inst_addr;
    sirius_pkg::wb_t wb_0;
    sirius_pkg::wb_t wb_1;

    // Program image and expected writebacks in program order
    logic [31:0]     imem [0:255];
    logic [31:0]     model_regs [0:31];
    sirius_pkg::wb_t exp_q [$];
    int              prog_len;
    int              fetch_mode;
    logic            fetch_on;
    logic            fetch_done;
    logic [31:0]     exp_addr;
    logic [31:0]     rng_state;
    string           test_name;
    int              errors;
    int              errors_at_start;
    int              tests_run;

    sirius_core #(.fifo_depth(8)) UUT (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            errors++;
            $display("ERR %s %s: expected %h actual %h", test_name, what, exp, act);
        end
    endtask

    // In-order model of the ALU subset
    function automatic void model_step(input logic [31:0] ins);
        logic [31:0]     a;
        logic [31:0]     b;
        logic [15:0]     imm;
        sirius_pkg::wb_t e;
        a      = model_regs[ins[25:21]];
        b      = model_regs[ins[20:16]];
        imm    = ins[15:0];
        e.wen  = 1'b1;
        e.dest = ins[20:16];
        e.data = '0;
        e.pc   = sirius_pkg::reset_pc + 32'(prog_len * 4);
        case (ins[31:26])
            sirius_pkg::opcode_special: begin
                e.dest = ins[15:11];
                case (ins[5:0])
                    sirius_pkg::funct_addu: e.data = a + b;
                    sirius_pkg::funct_subu: e.data = a - b;
                    sirius_pkg::funct_and:  e.data = a & b;
                    sirius_pkg::funct_or:   e.data = a | b;
                    sirius_pkg::funct_xor:  e.data = a ^ b;
                    sirius_pkg::funct_slt:  e.data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    sirius_pkg::funct_sll:  e.data = b << ins[10:6];
                    default:                e.wen = 1'b0;
                endcase
            end
            sirius_pkg::opcode_addiu: e.data = a + {{16{imm[15]}}, imm};
            sirius_pkg::opcode_andi:  e.data = a & {16'd0, imm};
            sirius_pkg::opcode_ori:   e.data = a | {16'd0, imm};
            sirius_pkg::opcode_xori:  e.data = a ^ {16'd0, imm};
            sirius_pkg::opcode_lui:   e.data = {imm, 16'd0};
            default:                  e.wen = 1'b0;
        endcase
        if (e.wen && e.dest != 5'd0) begin
            model_regs[e.dest] = e.data;
            exp_q.push_back(e);
        end
    endfunction

    function automatic void emit(input logic [31:0] ins);
        model_step(ins);
        imem[prog_len] = ins;
        prog_len++;
    endfunction

    task automatic start_test(input string name);
        @(posedge clk);
        fetch_on        = 1'b0;
        test_name       = name;
        errors_at_start = errors;
        prog_len        = 0;
        exp_q.delete();
        for (int i = 0; i < 32; i++)
            model_regs[i] = '0;
        @(negedge clk);
        rst <= 1'b1;
        repeat (5) @(negedge clk);
        rst <= 1'b0;
    endtask

    task automatic start_fetch(input int mode);
        @(posedge clk);
        fetch_mode = mode;
        exp_addr   = sirius_pkg::reset_pc;
        fetch_done = 1'b0;
        fetch_on   = 1'b1;
    endtask

    task automatic finish_program();
        int cycles;
        cycles = 0;
        while ((exp_q.size() != 0 || !fetch_done) && cycles < 4000) begin
            @(posedge clk);
            cycles++;
        end
        if (exp_q.size() != 0 || !fetch_done) begin
            errors++;
            $display("%s: timed out with %0d writebacks outstanding", test_name, exp_q.size());
        end
        fetch_on = 1'b0;
        // Quiet cycles catch repeated or stray writebacks
        repeat (8) @(posedge clk);
        @(negedge clk);
        check("final fetch address", sirius_pkg::reset_pc + 32'(prog_len * 4), inst_addr);
    endtask

    task automatic end_test();
        tests_run++;
        $display("%-14s %s, %0d errors", test_name,
                 (errors == errors_at_start) ? "ok" : "failed", errors - errors_at_start);
    endtask

    // Fetch side of the environment
    always @(negedge clk) begin : drive_fetch
        logic [31:0] idx;
        logic        two;
        logic        ok1;
        logic        ok2;
        ok1 = 1'b0;
        ok2 = 1'b0;
        if (fetch_on && !rst) begin
            check("fetch address", exp_addr, inst_addr);
            idx        = (inst_addr - sirius_pkg::reset_pc) >> 2;
            two        = (fetch_mode == 1) || (fetch_mode == 2 && (next_rand() & 32'd1) != 0);
            ok1        = (idx < prog_len);
            ok2        = two && (idx + 1 < prog_len);
            fetch_done = (idx >= prog_len);
            inst_data_1 <= imem[idx[7:0]];
            inst_data_2 <= imem[idx[7:0] + 8'd1];
            if (inst_en) begin
                exp_addr = exp_addr + (ok1 ? 32'd4 : 32'd0) + (ok2 ? 32'd4 : 32'd0);
            end
        end
        inst_ok_1 <= ok1;
        inst_ok_2 <= ok2;
    end

    task automatic compare_wb(input sirius_pkg::wb_t got);
        sirius_pkg::wb_t e;
        if (exp_q.size() == 0) begin
            errors++;
            $display("%s: unexpected writeback to r%0d from pc %h", test_name, got.dest, got.pc);
        end else begin
            e = exp_q.pop_front();
            check("wb pc", e.pc, got.pc);
            check("wb dest", 32'(e.dest), 32'(got.dest));
            check("wb data", e.data, got.data);
        end
    endtask

    // Lane 0 is older when both lanes write back together
    always @(negedge clk) begin
        if (!rst) begin
            if (wb_0.wen) begin
                compare_wb(wb_0);
            end
            if (wb_1.wen) begin
                compare_wb(wb_1);
            end
        end
    end

    `include "sirius_tests.svh"

    initial begin
        rst         = 1'b1;
        inst_ok_1   = 1'b0;
        inst_ok_2   = 1'b0;
        inst_data_1 = '0;
        inst_data_2 = '0;
        fetch_on    = 1'b0;
        fetch_done  = 1'b0;
        fetch_mode  = 0;
        exp_addr    = sirius_pkg::reset_pc;
        rng_state   = 32'hebf49638;
        errors      = 0;
        tests_run   = 0;
        prog_len    = 0;
        test_name   = "init";
        test_reset_state();
        test_single_fetch();
        test_dual_pairs();
        test_backpressure();
        test_random_mix();
        test_nop_handling();
        $display("%0d tests run, %0d errors", tests_run, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== sirius.f ====
+incdir+verification
design/sirius_pkg.sv
design/fetch_unit.sv
design/instruction_fifo.sv
design/register_file.sv
design/alu_lane.sv
design/dual_issue_pipeline.sv
design/sirius_core.sv
verification/sirius_tb.sv
